// ==== build.f ====
+incdir+hw
hw/p4_router_pkg.sv
hw/port_id_map.sv
hw/route_table.sv
hw/header_lookup.sv
hw/p4_router.sv
tests/p4_router_tb.sv

// ==== Makefile ====
# Verilator flow for the packet router
TOP = p4_router_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir -o router_sim
	./obj_dir/router_sim | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/p4_router_tb.sv ====
//////////////////////////////////////////////////////////////////////
// router testbench: table writes and packets from a step list, random
// out_ready stalls, beats and metadata checked against a lookup model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "p4_router_consts.svh"

module p4_router_tb;

    typedef struct packed {
        p4_router_pkg::axis_beat_t beat;
        logic                      sop;   // head beat, metadata expected
        p4_router_pkg::user_meta_t meta;
        logic [7:0]                row;   // step that sent it
    } exp_beat_t;

    typedef struct {
        string                  name;
        bit                     is_write;
        logic [7:0]             hw;      // ingress hw index
        logic [7:0]             dest;
        int                     beats;
        p4_router_pkg::tbl_wr_t wr;
    } step_t;

    localparam logic [7:0] p4_ids [`P4R_NUM_PORTS] = '{
        `P4R_CPU_P4_ID, `P4R_OISL0_P4_ID, `P4R_OISL1_P4_ID, `P4R_ECP0_P4_ID,
        `P4R_ECP1_P4_ID, `P4R_HDR0_P4_ID, `P4R_HDR1_P4_ID, `P4R_ECG0_P4_ID,
        `P4R_ECG1_P4_ID, `P4R_ECG2_P4_ID, `P4R_ECG3_P4_ID
    };

    logic                      clk;
    logic                      rst_n;
    p4_router_pkg::axis_beat_t in_beat;
    logic                      in_valid;
    logic                      in_ready;
    p4_router_pkg::user_meta_t in_meta;
    p4_router_pkg::axis_beat_t out_beat;
    logic                      out_valid;
    logic                      out_ready;
    p4_router_pkg::user_meta_t out_meta;
    logic                      out_meta_valid;
    logic                      tbl_wr_en;
    p4_router_pkg::tbl_wr_t    tbl_wr;
    logic                      miss_event;

    step_t       steps [$];
    exp_beat_t   exp_q [$];          // beats in flight, in order
    exp_beat_t   got_exp;
    logic        m_valid  [`P4R_TABLE_DEPTH];  // model of the route table
    logic [7:0]  m_port   [`P4R_TABLE_DEPTH];
    logic [7:0]  m_dest   [`P4R_TABLE_DEPTH];
    logic [7:0]  m_result [`P4R_TABLE_DEPTH];
    int unsigned errors      = 0;
    int unsigned exp_misses  = 0;
    int unsigned misses_seen = 0;
    int unsigned beats_seen  = 0;
    int unsigned total_beats = 0;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 100000;  // replaced once the steps are known

    p4_router i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_beat        (in_beat),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_meta        (in_meta),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_meta       (out_meta),
        .out_meta_valid (out_meta_valid),
        .tbl_wr_en      (tbl_wr_en),
        .tbl_wr         (tbl_wr),
        .miss_event     (miss_event)
    );

    //////////////////////////////////////////////////////////////////////
    // clock, stalls, timeout
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        void'($urandom(32'ha6cd_b623));
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = ($urandom % 4) != 0;  // roughly one stall in four
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: output did not drain within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // model of the port list and the lookup rule
    //////////////////////////////////////////////////////////////////////
    function automatic logic [7:0] p4_of_hw(input logic [7:0] hw);
        p4_of_hw = `P4R_PORT_UNKNOWN;
        for (int i = 0; i < `P4R_NUM_PORTS; i++) begin
            if (hw == 8'(i)) p4_of_hw = p4_ids[i];
        end
    endfunction

    function automatic logic [7:0] hw_of_p4(input logic [7:0] p4);
        hw_of_p4 = `P4R_PORT_UNKNOWN;                 // not in the list
        for (int i = 0; i < `P4R_NUM_PORTS; i++) begin
            if (p4 == p4_ids[i]) hw_of_p4 = 8'(i);
        end
    endfunction

    function automatic void route_model(input logic [7:0] port, input logic [7:0] dest,
                                        output logic hit, output logic [7:0] result);
        hit    = 1'b0;
        result = `P4R_PORT_UNKNOWN;
        for (int i = 0; i < `P4R_TABLE_DEPTH; i++) begin
            if (!hit && m_valid[i] && m_port[i] == port && m_dest[i] == dest) begin
                hit    = 1'b1;                         // first match wins
                result = m_result[i];
            end
        end
    endfunction

    task automatic check(input string name, input string field,
                         input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", name, field, expected, actual);
            errors = errors + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // step table
    //////////////////////////////////////////////////////////////////////
    task automatic add_pkt(input string name, input logic [7:0] hw,
                           input logic [7:0] dest, input int beats);
        step_t s;
        s.name     = name;
        s.is_write = 1'b0;
        s.hw       = hw;
        s.dest     = dest;
        s.beats    = beats;
        s.wr       = '0;
        steps.push_back(s);
    endtask

    task automatic add_wr(input string name, input logic [2:0] index, input logic valid,
                          input logic [7:0] port, input logic [7:0] dest,
                          input logic [7:0] result);
        step_t s;
        s.name           = name;
        s.is_write       = 1'b1;
        s.hw             = 8'h00;
        s.dest           = 8'h00;
        s.beats          = 0;
        s.wr.index       = index;
        s.wr.entry_valid = valid;
        s.wr.match_port  = port;
        s.wr.match_dest  = dest;
        s.wr.result_port = result;
        steps.push_back(s);
    endtask

    task automatic build_steps();
        add_pkt("miss_cpu",       8'd0,  8'h22, 3);   // empty table
        add_pkt("miss_oisl0",     8'd1,  8'h10, 2);
        add_wr ("wr_oisl0_ecg2",  3'd0, 1'b1, `P4R_OISL0_P4_ID, 8'h10, `P4R_ECG2_P4_ID);
        add_wr ("wr_cpu_hdr1",    3'd1, 1'b1, `P4R_CPU_P4_ID,   8'h22, `P4R_HDR1_P4_ID);
        add_pkt("hit_oisl0",      8'd1,  8'h10, 4);
        add_pkt("hit_cpu",        8'd0,  8'h22, 1);
        add_pkt("wrong_dest",     8'd1,  8'h11, 2);
        add_wr ("wr_oisl0_ecp0",  3'd5, 1'b1, `P4R_OISL0_P4_ID, 8'h10, `P4R_ECP0_P4_ID);
        add_pkt("prio_low_index", 8'd1,  8'h10, 2);   // entry 0 beats entry 5
        add_wr ("wr_clear_0",     3'd0, 1'b0, `P4R_OISL0_P4_ID, 8'h10, `P4R_ECG2_P4_ID);
        add_pkt("prio_after_clr", 8'd1,  8'h10, 3);
        add_wr ("wr_hdr0_bogus",  3'd3, 1'b1, `P4R_HDR0_P4_ID,  8'h55, 8'd50);
        add_pkt("hit_unlisted",   8'd5,  8'h55, 2);   // hit, but egress not in list
        add_pkt("ing_out_range",  8'd11, 8'h10, 2);
        add_pkt("ing_far_range",  8'd200, 8'h22, 1);
        add_pkt("stream_hdr1",    8'd6,  8'h40, 6);
        add_pkt("stream_single",  8'd2,  8'h41, 1);
        add_pkt("stream_long",    8'd10, 8'h42, 8);
    endtask

    //////////////////////////////////////////////////////////////////////
    // drivers, entered and left 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////
    task automatic apply_write(input int row);
        p4_router_pkg::tbl_wr_t w;
        w                  = steps[row].wr;
        tbl_wr             = w;
        tbl_wr_en          = 1'b1;
        m_valid[w.index]   = w.entry_valid;
        m_port[w.index]    = w.match_port;
        m_dest[w.index]    = w.match_dest;
        m_result[w.index]  = w.result_port;
        @(posedge clk);
        #1;
        tbl_wr_en = 1'b0;                              // one-cycle strobe
    endtask

    task automatic send_packet(input int row);
        p4_router_pkg::axis_beat_t beat;
        exp_beat_t                 item;
        logic                      hit;
        logic [7:0]                result;
        logic                      acc;
        route_model(p4_of_hw(steps[row].hw), steps[row].dest, hit, result);
        if (!hit) exp_misses = exp_misses + 1;
        in_meta.ing_port = steps[row].hw;
        in_meta.egr_spec = 8'h5a;                      // must be replaced
        for (int b = 0; b < steps[row].beats; b++) begin
            beat.tdata = {8'(row), 8'(b), 40'h5a_c3a5_0f1e, 8'(b)};
            if (b == 0) beat.tdata[7:0] = steps[row].dest;
            beat.tlast         = (b == steps[row].beats - 1);
            beat.tkeep         = beat.tlast ? 8'h0f : 8'hff;
            item.beat          = beat;
            item.sop           = (b == 0);
            item.meta.ing_port = steps[row].hw;
            item.meta.egr_spec = hw_of_p4(result);
            item.row           = 8'(row);
            exp_q.push_back(item);
            in_beat  = beat;
            in_valid = 1'b1;
            do begin
                @(negedge clk);
                acc = in_ready;                        // handshake at next edge
                @(posedge clk);
                #1;
            end while (!acc);
        end
        in_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // output checker, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            if (miss_event) misses_seen = misses_seen + 1;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat seen while no packet was outstanding");
                    errors = errors + 1;
                end else begin
                    got_exp    = exp_q.pop_front();
                    beats_seen = beats_seen + 1;
                    check(steps[got_exp.row].name, "tdata", got_exp.beat.tdata, out_beat.tdata);
                    check(steps[got_exp.row].name, "tkeep", 64'(got_exp.beat.tkeep),
                          64'(out_beat.tkeep));
                    check(steps[got_exp.row].name, "tlast", 64'(got_exp.beat.tlast),
                          64'(out_beat.tlast));
                    check(steps[got_exp.row].name, "meta_valid", 64'(got_exp.sop),
                          64'(out_meta_valid));
                    if (got_exp.sop) begin
                        check(steps[got_exp.row].name, "ing_port",
                              64'(got_exp.meta.ing_port), 64'(out_meta.ing_port));
                        check(steps[got_exp.row].name, "egr_spec",
                              64'(got_exp.meta.egr_spec), 64'(out_meta.egr_spec));
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        in_meta   = '0;
        tbl_wr_en = 1'b0;
        tbl_wr    = '0;
        for (int i = 0; i < `P4R_TABLE_DEPTH; i++) begin
            m_valid[i]  = 1'b0;                        // table empty after reset
            m_port[i]   = 8'h00;
            m_dest[i]   = 8'h00;
            m_result[i] = 8'h00;
        end
        build_steps();
        for (int i = 0; i < steps.size(); i++) begin
            total_beats = total_beats + 32'(steps[i].beats);
        end
        cycle_limit = total_beats * 4 + 200;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int row = 0; row < steps.size(); row++) begin
            if (steps[row].is_write) apply_write(row);
            else send_packet(row);
        end
        while (exp_q.size() != 0) @(posedge clk);      // drain, bounded by timeout
        repeat (4) @(posedge clk);
        check("end_of_run", "miss_count", 64'(exp_misses), 64'(misses_seen));
        $display("beats checked %0d of %0d, errors %0d", beats_seen, total_beats, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hw/p4_router.sv ====
//////////////////////////////////////////////////////////////////////
// router top: port map, route table and header pipeline on one clock
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module p4_router (
    input  logic                      clk,
    input  logic                      rst_n,

    input  p4_router_pkg::axis_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  p4_router_pkg::user_meta_t in_meta,

    output p4_router_pkg::axis_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output p4_router_pkg::user_meta_t out_meta,
    output logic                      out_meta_valid,

    input  logic                      tbl_wr_en,
    input  p4_router_pkg::tbl_wr_t    tbl_wr,

    output logic                      miss_event
);

    p4_router_pkg::p4_port_t   ing_p4;       // mapped ingress key
    p4_router_pkg::dest_addr_t key_dest;     // from first beat
    logic                      hit;
    p4_router_pkg::p4_port_t   result_port;  // pipeline egress
    p4_router_pkg::hw_port_t   egr_hw;       // back to hw index

    port_id_map i_port_id_map (
        .ing_hw (in_meta.ing_port),
        .ing_p4 (ing_p4),
        .egr_p4 (result_port),
        .egr_hw (egr_hw)
    );

    route_table i_route_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .tbl_wr_en   (tbl_wr_en),
        .tbl_wr      (tbl_wr),
        .key_port    (ing_p4),
        .key_dest    (key_dest),
        .hit         (hit),
        .result_port (result_port)
    );

    header_lookup i_header_lookup (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_beat        (in_beat),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_meta        (in_meta),
        .key_dest       (key_dest),
        .hit            (hit),
        .egr_hw         (egr_hw),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_meta       (out_meta),
        .out_meta_valid (out_meta_valid),
        .miss_event     (miss_event)
    );

endmodule

// ==== hw/header_lookup.sv ====
//////////////////////////////////////////////////////////////////////
// one-stage packet register; keys the lookup off the first beat and
// attaches the routed metadata to the outgoing packet
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module header_lookup (
    input  logic                      clk,
    input  logic                      rst_n,

    input  p4_router_pkg::axis_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  p4_router_pkg::user_meta_t in_meta,     // taken with first beat

    output p4_router_pkg::dest_addr_t key_dest,    // to route table
    input  logic                      hit,         // from route table
    input  p4_router_pkg::hw_port_t   egr_hw,      // mapped lookup result

    output p4_router_pkg::axis_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output p4_router_pkg::user_meta_t out_meta,
    output logic                      out_meta_valid,  // first output beat only

    output logic                      miss_event       // one pulse per missed packet
);

    logic in_sop;     // next accepted beat opens a packet
    logic in_accept;  // beat moves this cycle

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////
    assign in_ready  = !out_valid || out_ready;                // slot free or draining
    assign in_accept = in_valid && in_ready;
    assign key_dest  = in_beat.tdata[7:0];                     // dest addr byte

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_sop <= 1'b1;                                    // first beat after reset
        end else if (in_accept) begin
            in_sop <= in_beat.tlast;                           // tlast rearms
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid      <= 1'b0;
            out_meta_valid <= 1'b0;
            miss_event     <= 1'b0;
        end else begin
            miss_event <= in_accept && in_sop && !hit;         // lines up with first beat out
            if (in_accept) begin
                out_valid      <= 1'b1;
                out_meta_valid <= in_sop;                      // high for the head beat only
            end else if (out_ready) begin
                out_valid      <= 1'b0;                        // beat taken, nothing new
                out_meta_valid <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (in_accept) begin
            out_beat <= in_beat;
        end
        if (in_accept && in_sop) begin
            out_meta.ing_port <= in_meta.ing_port;             // original hw index
            out_meta.egr_spec <= egr_hw;                       // routed egress, 255 on miss
        end
    end

endmodule

// ==== hw/route_table.sv ====
//////////////////////////////////////////////////////////////////////
// programmable route table; strobe writes, combinational lookup
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "p4_router_consts.svh"

module route_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tbl_wr_en,    // single-cycle strobe
    input  p4_router_pkg::tbl_wr_t    tbl_wr,
    input  p4_router_pkg::p4_port_t   key_port,     // mapped ingress
    input  p4_router_pkg::dest_addr_t key_dest,     // first header byte
    output logic                      hit,
    output p4_router_pkg::p4_port_t   result_port
);

    //////////////////////////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////////////////////////
    logic [`P4R_TABLE_DEPTH-1:0] entry_valid;                        // per-entry valid
    p4_router_pkg::p4_port_t     match_port_q  [`P4R_TABLE_DEPTH];
    p4_router_pkg::dest_addr_t   match_dest_q  [`P4R_TABLE_DEPTH];
    p4_router_pkg::p4_port_t     result_port_q [`P4R_TABLE_DEPTH];
    logic [`P4R_TABLE_DEPTH-1:0] match_vec;                          // parallel compare hits

    // per-entry valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= '0;                                       // all entries invalid
        end else if (tbl_wr_en) begin
            entry_valid[tbl_wr.index] <= tbl_wr.entry_valid;
        end
    end

    // match fields and result
    always_ff @(posedge clk) begin
        if (tbl_wr_en) begin
            match_port_q[tbl_wr.index]  <= tbl_wr.match_port;
            match_dest_q[tbl_wr.index]  <= tbl_wr.match_dest;
            result_port_q[tbl_wr.index] <= tbl_wr.result_port;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `P4R_TABLE_DEPTH; i++) begin
            match_vec[i] = entry_valid[i]
                           && (match_port_q[i] == key_port)
                           && (match_dest_q[i] == key_dest);
        end
    end

    // walk from the top down so the lowest index is written last and wins
    always_comb begin
        hit         = 1'b0;
        result_port = `P4R_PORT_UNKNOWN;                             // miss default
        for (int i = `P4R_TABLE_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit         = 1'b1;
                result_port = result_port_q[i];
            end
        end
    end

endmodule

// ==== hw/port_id_map.sv ====
//////////////////////////////////////////////////////////////////////
// maps hardware port indices to pipeline port numbers and back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "p4_router_consts.svh"

module port_id_map (
    input  p4_router_pkg::hw_port_t ing_hw,  // hw ingress index
    output p4_router_pkg::p4_port_t ing_p4,  // pipeline ingress port
    input  p4_router_pkg::p4_port_t egr_p4,  // pipeline egress port
    output p4_router_pkg::hw_port_t egr_hw   // hw egress index
);

    //////////////////////////////////////////////////////////////////////
    // ingress: hw index -> pipeline port
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ing_hw)
            8'd0:    ing_p4 = `P4R_CPU_P4_ID;
            8'd1:    ing_p4 = `P4R_OISL0_P4_ID;
            8'd2:    ing_p4 = `P4R_OISL1_P4_ID;
            8'd3:    ing_p4 = `P4R_ECP0_P4_ID;
            8'd4:    ing_p4 = `P4R_ECP1_P4_ID;
            8'd5:    ing_p4 = `P4R_HDR0_P4_ID;
            8'd6:    ing_p4 = `P4R_HDR1_P4_ID;
            8'd7:    ing_p4 = `P4R_ECG0_P4_ID;
            8'd8:    ing_p4 = `P4R_ECG1_P4_ID;
            8'd9:    ing_p4 = `P4R_ECG2_P4_ID;
            8'd10:   ing_p4 = `P4R_ECG3_P4_ID;
            default: ing_p4 = `P4R_PORT_UNKNOWN;  // out of range -> unknown
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // egress: pipeline port -> hw index
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (egr_p4)
            `P4R_CPU_P4_ID:   egr_hw = 8'd0;
            `P4R_OISL0_P4_ID: egr_hw = 8'd1;
            `P4R_OISL1_P4_ID: egr_hw = 8'd2;
            `P4R_ECP0_P4_ID:  egr_hw = 8'd3;
            `P4R_ECP1_P4_ID:  egr_hw = 8'd4;
            `P4R_HDR0_P4_ID:  egr_hw = 8'd5;
            `P4R_HDR1_P4_ID:  egr_hw = 8'd6;
            `P4R_ECG0_P4_ID:  egr_hw = 8'd7;
            `P4R_ECG1_P4_ID:  egr_hw = 8'd8;
            `P4R_ECG2_P4_ID:  egr_hw = 8'd9;
            `P4R_ECG3_P4_ID:  egr_hw = 8'd10;
            default:          egr_hw = `P4R_PORT_UNKNOWN;  // misses land here too
        endcase
    end

endmodule

// ==== hw/p4_router_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types for the router; referenced as p4_router_pkg::name
//////////////////////////////////////////////////////////////////////
`include "p4_router_consts.svh"

package p4_router_pkg;

    typedef logic [7:0] hw_port_t;    // hardware port index
    typedef logic [7:0] p4_port_t;    // pipeline port number
    typedef logic [7:0] dest_addr_t;  // first header byte
    typedef logic [$clog2(`P4R_TABLE_DEPTH)-1:0] tbl_index_t;

    // one 64-bit stream beat
    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;   // byte enables
        logic        tlast;   // end of packet
    } axis_beat_t;

    // per-packet user metadata, ingress in the upper byte
    typedef struct packed {
        hw_port_t ing_port;
        hw_port_t egr_spec;
    } user_meta_t;

    // single table write from the control path
    typedef struct packed {
        tbl_index_t index;
        logic       entry_valid;  // 0 clears the entry
        p4_port_t   match_port;
        dest_addr_t match_dest;
        p4_port_t   result_port;
    } tbl_wr_t;

endpackage

// ==== hw/p4_router_consts.svh ====
//////////////////////////////////////////////////////////////////////
// router constants: port ids, table depth and the unknown-port code
//////////////////////////////////////////////////////////////////////
`ifndef P4_ROUTER_CONSTS_SVH
`define P4_ROUTER_CONSTS_SVH

`define P4R_NUM_PORTS    11     // hardware ports 0..10
`define P4R_TABLE_DEPTH  8      // route entries
`define P4R_PORT_UNKNOWN 8'hFF  // unmapped port or lookup miss

// pipeline port numbers, grouped by interface class
`define P4R_CPU_P4_ID    8'd0
`define P4R_OISL0_P4_ID  8'd20
`define P4R_OISL1_P4_ID  8'd21
`define P4R_ECP0_P4_ID   8'd40
`define P4R_ECP1_P4_ID   8'd41
`define P4R_HDR0_P4_ID   8'd60
`define P4R_HDR1_P4_ID   8'd61
`define P4R_ECG0_P4_ID   8'd80
`define P4R_ECG1_P4_ID   8'd81
`define P4R_ECG2_P4_ID   8'd82
`define P4R_ECG3_P4_ID   8'd83

`endif
